/* build.f */
+incdir+include
hdl/ctr_pkg.sv
hdl/obs_fifo_if.sv
hdl/ctr_observe.sv
hdl/obs_fifo.sv
hdl/obs_trace_out.sv
hdl/ctr_observer_top.sv
testbench/tb_ctr_observer.sv

/* Makefile */
TOP := tb_ctr_observer
OBJ := obj_dir

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f build.f --top-module ctr_observer_top

sim:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module $(TOP) -Mdir $(OBJ)
	./$(OBJ)/V$(TOP) | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf $(OBJ) sim.log

/* testbench/tb_ctr_observer.sv */
`timescale 1ns/100ps
`default_nettype none

`include "ctr_config.svh"

module tb_ctr_observer;

	// stimulus cycles of all tests without drains and resets
	localparam int STIM_CYCLES = 30 + 60 + 60 + 60 + 80 + (`CTR_OBS_DEPTH + 2) + 2;
	localparam int WATCHDOG_CYCLES = STIM_CYCLES * 4 + 200;

	logic                       clk;
	logic                       rst_n;
	logic                       retire;
	logic [`CTR_XLEN-1:0]       instr;
	logic [`CTR_XLEN-1:0]       pc;
	logic [`CTR_XLEN-1:0]       rs1_data;
	logic [`CTR_XLEN-1:0]       rs2_data;
	logic                       stall;
	logic [`CTR_REG_ADDR_W-1:0] rs1_addr;
	logic [`CTR_REG_ADDR_W-1:0] rs2_addr;
	logic                       trace_valid;
	logic [`CTR_XLEN-1:0]       trace_pc;
	ctr_pkg::obs_kind_e         trace_kind;
	logic [`CTR_XLEN-1:0]       trace_value;
	logic                       overflow;

	int                seed;
	int                errors;
	int                tests_run;
	int                tests_failed;
	int                occ;
	int                n_recv;
	logic              exp_valid;
	logic              exp_ovf;
	logic              prev_stall;
	ctr_pkg::obs_rec_t exp_q[$];

	ctr_observer_top u_dut (
		.clk_i         (clk),
		.rst_n_i       (rst_n),
		.retire_i      (retire),
		.instr_i       (instr),
		.pc_i          (pc),
		.rs1_data_i    (rs1_data),
		.rs2_data_i    (rs2_data),
		.trace_stall_i (stall),
		.rs1_addr_o    (rs1_addr),
		.rs2_addr_o    (rs2_addr),
		.trace_valid_o (trace_valid),
		.trace_pc_o    (trace_pc),
		.trace_kind_o  (trace_kind),
		.trace_value_o (trace_value),
		.overflow_o    (overflow)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Test failures found");
		$finish;
	end

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			errors++;
			$display("ERR %s expected %h got %h at %0t", name, exp, act, $time);
		end
	endtask

	function automatic logic is_observable(input logic [31:0] ins);
		return (ins[6:0] == `CTR_OPC_LOAD) || (ins[6:0] == `CTR_OPC_STORE) ||
			(ins[6:0] == `CTR_OPC_BRANCH);
	endfunction

	// expected record straight from the ISA rules
	function automatic ctr_pkg::obs_rec_t expected_rec(input logic [31:0] ins,
			input logic [31:0] pcv, input logic [31:0] a, input logic [31:0] b);
		ctr_pkg::obs_rec_t r;
		logic [31:0]       imm_i;
		logic [31:0]       imm_s;
		logic              take;
		imm_i = {{20{ins[31]}}, ins[31:20]};
		imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
		r.pc = pcv;
		if (ins[6:0] == `CTR_OPC_LOAD) begin
			r.kind  = ctr_pkg::OBS_LOAD;
			r.value = a + imm_i;
		end else if (ins[6:0] == `CTR_OPC_STORE) begin
			r.kind  = ctr_pkg::OBS_STORE;
			r.value = a + imm_s;
		end else begin
			case (ins[14:12])
				3'b001:  take = (a != b);
				3'b100:  take = ($signed(a) < $signed(b));
				3'b101:  take = ($signed(a) >= $signed(b));
				3'b110:  take = (a < b);
				3'b111:  take = (a >= b);
				// 000, and the unlisted 010 and 011, compare for equality
				default: take = (a == b);
			endcase
			r.kind  = ctr_pkg::OBS_BRANCH;
			r.value = {31'b0, take};
		end
		return r;
	endfunction

	// outputs are stable at the falling edge
	always @(negedge clk) begin : monitor
		ctr_pkg::obs_rec_t got;
		if (!rst_n) begin
			exp_q.delete();
			occ = 0;
			exp_valid = 1'b0;
			exp_ovf = 1'b0;
			prev_stall = 1'b0;
		end else begin
			check("trace_valid_o", exp_valid, trace_valid);
			if (prev_stall) begin
				check("trace_valid_o after stall", 1'b0, trace_valid);
			end
			if (trace_valid) begin
				n_recv++;
				occ--;
				if (exp_q.size() == 0) begin
					errors++;
					$display("A trace record came out while none was expected");
				end else begin
					got = exp_q.pop_front();
					check("trace_pc_o", got.pc, trace_pc);
					check("trace_kind_o", got.kind, trace_kind);
					check("trace_value_o", got.value, trace_value);
				end
			end
			check("overflow_o", exp_ovf, overflow);
			check("rs1_addr_o", instr[19:15], rs1_addr);
			check("rs2_addr_o", instr[24:20], rs2_addr);
			// pop at the coming edge depends on the count before any push
			exp_valid = (occ > 0) && !stall;
			if (retire && is_observable(instr)) begin
				if (occ < `CTR_OBS_DEPTH) begin
					exp_q.push_back(expected_rec(instr, pc, rs1_data, rs2_data));
					occ++;
				end else begin
					exp_ovf = 1'b1;
				end
			end
			prev_stall = stall;
		end
	end

	// one cycle of stimulus where kind 3 is an opcode the observer ignores
	task automatic step(input logic ret, input logic [1:0] kind, input logic st);
		logic [31:0] ins;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] pcv;
		ins = $random(seed);
		pcv = $random(seed);
		a = $random(seed);
		b = (($random(seed) & 3) == 0) ? a : $random(seed);
		case (kind)
			2'd0:    ins[6:0] = `CTR_OPC_LOAD;
			2'd1:    ins[6:0] = `CTR_OPC_STORE;
			2'd2:    ins[6:0] = `CTR_OPC_BRANCH;
			default: ins[6:0] = 7'h33;
		endcase
		@(posedge clk);
		retire <= ret;
		instr <= ins;
		pc <= {pcv[31:2], 2'b00};
		rs1_data <= a;
		rs2_data <= b;
		stall <= st;
	endtask

	task automatic drain();
		step(1'b0, 2'd0, 1'b0);
		while (exp_q.size() > 0) begin
			step(1'b0, 2'd0, 1'b0);
		end
	endtask

	task automatic reset_dut();
		@(posedge clk);
		rst_n <= 1'b0;
		retire <= 1'b0;
		stall <= 1'b0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
	endtask

	task automatic report(input string name, input int err0);
		tests_run++;
		if (errors > err0) begin
			tests_failed++;
		end
		$display("test %0d %s: %s", tests_run, name, (errors > err0) ? "FAILED" : "ok");
	endtask

	// mode 0 loads and stores, 1 branches, 2 any opcode
	task automatic run_test(input string name, input int cycles, input int mode,
			input logic use_stall);
		int         err0;
		logic [1:0] kind;
		logic       st;
		err0 = errors;
		st = 1'b0;
		for (int i = 0; i < cycles; i++) begin
			case (mode)
				0:       kind = {1'b0, 1'($random(seed))};
				1:       kind = 2'd2;
				default: kind = 2'($random(seed));
			endcase
			// stall comes in runs of random length
			if (use_stall && (($random(seed) & 3) == 0)) begin
				st = ~st;
			end
			step(1'($random(seed)), kind, st);
		end
		drain();
		report(name, err0);
	endtask

	task automatic overflow_test();
		int err0;
		int n0;
		err0 = errors;
		reset_dut();
		n0 = n_recv;
		repeat (`CTR_OBS_DEPTH + 2) step(1'b1, 2'd0, 1'b1);
		repeat (2) step(1'b0, 2'd0, 1'b1);
		@(negedge clk);
		check("overflow_o while stalled", 1'b1, overflow);
		check("records out while stalled", 0, n_recv - n0);
		drain();
		@(negedge clk);
		check("records drained", `CTR_OBS_DEPTH, n_recv - n0);
		check("overflow_o after drain", 1'b1, overflow);
		reset_dut();
		@(negedge clk);
		check("overflow_o after reset", 1'b0, overflow);
		report("overflow under stall", err0);
	endtask

	initial begin
		seed = 30597;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		occ = 0;
		n_recv = 0;
		exp_valid = 1'b0;
		exp_ovf = 1'b0;
		prev_stall = 1'b0;
		rst_n = 1'b0;
		retire = 1'b0;
		instr = '0;
		pc = '0;
		rs1_data = '0;
		rs2_data = '0;
		stall = 1'b0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		run_test("source register addresses", 30, 2, 1'b0);
		run_test("loads and stores", 60, 0, 1'b0);
		run_test("branch compares", 60, 1, 1'b0);
		run_test("ignored opcodes", 60, 2, 1'b0);
		run_test("random stall", 80, 2, 1'b1);
		overflow_test();
		$display("%0d tests run, %0d failed, %0d check errors",
			tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* hdl/ctr_observer_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "ctr_config.svh"

module ctr_observer_top (
	input  wire logic                       clk_i,
	input  wire logic                       rst_n_i,
	input  wire logic                       retire_i,
	input  wire logic [`CTR_XLEN-1:0]       instr_i,
	input  wire logic [`CTR_XLEN-1:0]       pc_i,
	input  wire logic [`CTR_XLEN-1:0]       rs1_data_i,
	input  wire logic [`CTR_XLEN-1:0]       rs2_data_i,
	input  wire logic                       trace_stall_i,
	output logic      [`CTR_REG_ADDR_W-1:0] rs1_addr_o,
	output logic      [`CTR_REG_ADDR_W-1:0] rs2_addr_o,
	output logic                            trace_valid_o,
	output logic      [`CTR_XLEN-1:0]       trace_pc_o,
	output ctr_pkg::obs_kind_e              trace_kind_o,
	output logic      [`CTR_XLEN-1:0]       trace_value_o,
	output logic                            overflow_o
);

	// record queue between decode and trace port
	obs_fifo_if #(.T(ctr_pkg::obs_rec_t)) obs_q ();

	ctr_observe u_observe (
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.retire_i   (retire_i),
		.instr_i    (instr_i),
		.pc_i       (pc_i),
		.rs1_data_i (rs1_data_i),
		.rs2_data_i (rs2_data_i),
		.rs1_addr_o (rs1_addr_o),
		.rs2_addr_o (rs2_addr_o),
		.overflow_o (overflow_o),
		.q          (obs_q)
	);

	obs_fifo #(
		.T(ctr_pkg::obs_rec_t)
	) u_fifo (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.q       (obs_q)
	);

	obs_trace_out u_trace (
		.clk_i         (clk_i),
		.rst_n_i       (rst_n_i),
		.trace_stall_i (trace_stall_i),
		.trace_valid_o (trace_valid_o),
		.trace_pc_o    (trace_pc_o),
		.trace_kind_o  (trace_kind_o),
		.trace_value_o (trace_value_o),
		.q             (obs_q)
	);

endmodule

`default_nettype wire

/* hdl/obs_trace_out.sv */
`timescale 1ns/100ps
`default_nettype none

`include "ctr_config.svh"

module obs_trace_out (
	input  wire logic                 clk_i,
	input  wire logic                 rst_n_i,
	input  wire logic                 trace_stall_i,
	output logic                      trace_valid_o,
	output logic [`CTR_XLEN-1:0]      trace_pc_o,
	output ctr_pkg::obs_kind_e        trace_kind_o,
	output logic [`CTR_XLEN-1:0]      trace_value_o,
	obs_fifo_if.consumer              q
);

	logic              valid_q;
	ctr_pkg::obs_rec_t rec_q;

	// drain whenever something is queued and the port is free
	assign q.pop = ~q.empty & ~trace_stall_i;

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= q.pop;
		end
	end

	always_ff @(posedge clk_i) begin
		if (q.pop) begin
			rec_q <= q.pop_data;
		end
	end

	assign trace_valid_o = valid_q;
	assign trace_pc_o    = rec_q.pc;
	assign trace_kind_o  = rec_q.kind;
	assign trace_value_o = rec_q.value;

	// a stalled cycle without a pop yields no record next cycle
	a_no_valid_after_stall: assert property (
		@(posedge clk_i) disable iff (!rst_n_i)
		(trace_stall_i && !q.pop) |=> !trace_valid_o
	);

endmodule

`default_nettype wire

/* hdl/obs_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

`include "ctr_config.svh"

module obs_fifo #(
	parameter type T = ctr_pkg::obs_rec_t
) (
	input  wire logic  clk_i,
	input  wire logic  rst_n_i,
	obs_fifo_if.buffer q
);

	localparam int unsigned DEPTH = `CTR_OBS_DEPTH;
	localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int unsigned CNT_W = $clog2(DEPTH + 1);

	T                  mem [DEPTH];
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic [CNT_W-1:0]  count;

	// payload storage
	always_ff @(posedge clk_i) begin
		if (q.push) begin
			mem[wr_ptr] <= q.push_data;
		end
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (q.push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (q.pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			// push and pop together leave the count alone
			case ({q.push, q.pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign q.full     = (count == CNT_W'(DEPTH));
	assign q.empty    = (count == '0);
	assign q.pop_data = mem[rd_ptr];

	// producer must respect full
	a_no_push_when_full: assert property (
		@(posedge clk_i) disable iff (!rst_n_i)
		q.push |-> !q.full
	);

	// consumer must respect empty
	a_no_pop_when_empty: assert property (
		@(posedge clk_i) disable iff (!rst_n_i)
		q.pop |-> !q.empty
	);

	a_count_in_range: assert property (
		@(posedge clk_i) disable iff (!rst_n_i)
		count <= CNT_W'(DEPTH)
	);

endmodule

`default_nettype wire

/* hdl/ctr_observe.sv */
`timescale 1ns/100ps
`default_nettype none

`include "ctr_config.svh"

module ctr_observe (
	input  wire logic                       clk_i,
	input  wire logic                       rst_n_i,
	input  wire logic                       retire_i,
	input  wire logic [`CTR_XLEN-1:0]       instr_i,
	input  wire logic [`CTR_XLEN-1:0]       pc_i,
	input  wire logic [`CTR_XLEN-1:0]       rs1_data_i,
	input  wire logic [`CTR_XLEN-1:0]       rs2_data_i,
	output logic      [`CTR_REG_ADDR_W-1:0] rs1_addr_o,
	output logic      [`CTR_REG_ADDR_W-1:0] rs2_addr_o,
	output logic                            overflow_o,
	obs_fifo_if.producer                    q
);

	logic [6:0]           opcode;
	logic                 is_load;
	logic                 is_store;
	logic                 is_branch;
	logic                 observable;
	logic [`CTR_XLEN-1:0] imm_i_type;
	logic [`CTR_XLEN-1:0] imm_s_type;
	logic [`CTR_XLEN-1:0] imm;
	logic [`CTR_XLEN+1:0] addr_sum;
	logic [`CTR_XLEN-1:0] eff_addr;
	logic [`CTR_XLEN+1:0] diff_sum;
	logic [`CTR_XLEN-1:0] diff;
	logic                 is_equal;
	logic                 is_greater_equal;
	logic                 cmp_signed;
	logic                 taken;
	ctr_pkg::cmp_op_e     cmp_op;
	ctr_pkg::obs_rec_t    rec;
	logic                 overflow_q;

	assign opcode     = instr_i[6:0];
	assign is_load    = (opcode == `CTR_OPC_LOAD);
	assign is_store   = (opcode == `CTR_OPC_STORE);
	assign is_branch  = (opcode == `CTR_OPC_BRANCH);
	assign observable = is_load | is_store | is_branch;

	// source registers go straight back to the core
	assign rs1_addr_o = instr_i[19:15];
	assign rs2_addr_o = instr_i[24:20];

	assign imm_i_type = {{(`CTR_XLEN-12){instr_i[31]}}, instr_i[31:20]};
	assign imm_s_type = {{(`CTR_XLEN-12){instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
	assign imm = is_load ? imm_i_type : is_store ? imm_s_type : '0;

	// the appended low bits supply the carry-in
	assign addr_sum = {1'b0, rs1_data_i, 1'b1} + {1'b0, imm, 1'b0};
	assign eff_addr = addr_sum[`CTR_XLEN:1];

	// a - b as a + ~b + 1 through the same shifted form
	assign diff_sum = {1'b0, rs1_data_i, 1'b1} +
		{1'b0, ({rs2_data_i, 1'b0} ^ {(`CTR_XLEN+1){1'b1}})};
	assign diff     = diff_sum[`CTR_XLEN:1];
	assign is_equal = (diff == '0);

	always_comb begin
		case (instr_i[14:12])
			`CTR_F3_BEQ:  cmp_op = ctr_pkg::CMP_EQ;
			`CTR_F3_BNE:  cmp_op = ctr_pkg::CMP_NE;
			`CTR_F3_BLT:  cmp_op = ctr_pkg::CMP_LT;
			`CTR_F3_BGE:  cmp_op = ctr_pkg::CMP_GE;
			`CTR_F3_BLTU: cmp_op = ctr_pkg::CMP_LTU;
			`CTR_F3_BGEU: cmp_op = ctr_pkg::CMP_GEU;
			default:      cmp_op = ctr_pkg::CMP_EQ;
		endcase
	end

	assign cmp_signed = (cmp_op == ctr_pkg::CMP_LT) || (cmp_op == ctr_pkg::CMP_GE);

	// the difference decides for equal signs and the sign of a otherwise
	always_comb begin
		if ((rs1_data_i[`CTR_XLEN-1] ^ rs2_data_i[`CTR_XLEN-1]) == 1'b0) begin
			is_greater_equal = (diff[`CTR_XLEN-1] == 1'b0);
		end else begin
			is_greater_equal = rs1_data_i[`CTR_XLEN-1] ^ cmp_signed;
		end
	end

	always_comb begin
		case (cmp_op)
			ctr_pkg::CMP_NE:                  taken = ~is_equal;
			ctr_pkg::CMP_GE, ctr_pkg::CMP_GEU: taken = is_greater_equal;
			ctr_pkg::CMP_LT, ctr_pkg::CMP_LTU: taken = ~is_greater_equal;
			default:                          taken = is_equal;
		endcase
	end

	always_comb begin
		rec.pc = pc_i;
		if (is_load) begin
			rec.kind  = ctr_pkg::OBS_LOAD;
			rec.value = eff_addr;
		end else if (is_store) begin
			rec.kind  = ctr_pkg::OBS_STORE;
			rec.value = eff_addr;
		end else begin
			rec.kind  = ctr_pkg::OBS_BRANCH;
			rec.value = {{(`CTR_XLEN-1){1'b0}}, taken};
		end
	end

	// written at the edge closing the retire cycle
	assign q.push      = retire_i & observable & ~q.full;
	assign q.push_data = rec;

	// set by a dropped record and held until reset
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			overflow_q <= 1'b0;
		end else if (retire_i && observable && q.full) begin
			overflow_q <= 1'b1;
		end
	end

	assign overflow_o = overflow_q;

endmodule

`default_nettype wire

/* hdl/obs_fifo_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface obs_fifo_if #(
	parameter type T = ctr_pkg::obs_rec_t
);

	// write side
	logic push;
	T     push_data;
	logic full;

	// read side
	logic pop;
	// always the oldest entry
	T     pop_data;
	logic empty;

	modport producer (
		output push,
		output push_data,
		input  full
	);

	modport buffer (
		input  push,
		input  push_data,
		output full,
		input  pop,
		output pop_data,
		output empty
	);

	modport consumer (
		output pop,
		input  pop_data,
		input  empty
	);

endinterface

`default_nettype wire

/* hdl/ctr_pkg.sv */
`default_nettype none

`include "ctr_config.svh"

package ctr_pkg;

	// kind of retired instruction carried by a record
	typedef enum logic [1:0] {
		OBS_LOAD   = 2'd0,
		OBS_STORE  = 2'd1,
		OBS_BRANCH = 2'd2
	} obs_kind_e;

	// branch compare selected from funct3
	typedef enum logic [2:0] {
		CMP_EQ,
		CMP_NE,
		CMP_LT,
		CMP_GE,
		CMP_LTU,
		CMP_GEU
	} cmp_op_e;

	// one observation of 66 bits
	// value is the effective address, or the taken bit for a branch
	typedef struct packed {
		logic [`CTR_XLEN-1:0] pc;
		obs_kind_e            kind;
		logic [`CTR_XLEN-1:0] value;
	} obs_rec_t;

endpackage

`default_nettype wire

/* include/ctr_config.svh */
`ifndef CTR_CONFIG_SVH
`define CTR_CONFIG_SVH

// datapath widths
`define CTR_XLEN        32
`define CTR_REG_ADDR_W  5

// major opcodes that the observer records
`define CTR_OPC_LOAD    7'h03
`define CTR_OPC_STORE   7'h23
`define CTR_OPC_BRANCH  7'h63

// branch funct3 codes
`define CTR_F3_BEQ      3'b000
`define CTR_F3_BNE      3'b001
`define CTR_F3_BLT      3'b100
`define CTR_F3_BGE      3'b101
`define CTR_F3_BLTU     3'b110
`define CTR_F3_BGEU     3'b111

// number of records the trace queue holds
`define CTR_OBS_DEPTH   4

`endif
